// ==== flist.f ====
+incdir+src
src/l2_pkg.sv
src/l2_req_latch.sv
src/l2_tag_store.sv
src/l2_lru.sv
src/l2_ctrl_fsm.sv
src/l2_mem_port.sv
src/l2_cache_ctrl.sv
sim/tb_clk_gen.sv
sim/l2_cache_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module l2_cache_ctrl_tb -o l2_sim
./obj_dir/l2_sim | tee sim.log

if grep -qx "TEST PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== sim/l2_cache_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_cache_ctrl_tb;

    localparam int TIMEOUT = 200;

    logic            clk;
    logic            nrst;
    logic            read_req;
    logic            write_req;
    logic            flush;
    logic            mem_ready;
    l2_pkg::tag_t    req_tag;
    l2_pkg::index_t  req_index;
    logic            ready;
    logic            refill;
    logic            update;
    logic            mem_read;
    logic            mem_write;
    l2_pkg::index_t  mem_index;
    l2_pkg::tag_t    mem_tag;
    logic [1:0]      way;

    // reference model of the tag side
    l2_pkg::tag_t    m_tag [256][4];
    logic [3:0]      m_valid [256];
    logic [3:0]      m_dirty [256];
    logic [1:0]      m_age [256][4];

    int              errors;
    int              tests;
    int              failed;
    int              cycles;
    logic            timed_out;
    logic            saw_wb;
    logic            saw_rd;
    logic            saw_refill;
    logic            saw_upd;
    logic            wb_first;
    logic [1:0]      fill_way;
    logic [1:0]      end_way;
    l2_pkg::tag_t    wb_tag;
    l2_pkg::tag_t    rd_tag;
    l2_pkg::index_t  rd_index;
    l2_pkg::tag_t    tag_a;
    l2_pkg::tag_t    tag_b;

    tb_clk_gen clk_gen_inst (.clk(clk), .nrst(nrst));

    l2_cache_ctrl l2_cache_ctrl_inst (
        .clk(clk), .nrst(nrst), .read_req(read_req), .write_req(write_req),
        .flush(flush), .req_tag(req_tag), .req_index(req_index), .mem_ready(mem_ready),
        .ready(ready), .refill(refill), .update(update), .mem_read(mem_read),
        .mem_write(mem_write), .mem_index(mem_index), .mem_tag(mem_tag), .way(way)
    );

    task automatic report_mismatch(input string msg);
        $display("mismatch at %0d ns: %s", $time, msg);
        errors++;
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests++;
        if (errors == err_before)
            $display("%s: ok", name);
        else
        begin
            failed++;
            $display("%s: failed, %0d errors", name, errors - err_before);
        end
    endtask

    function automatic void model_reset();
        for (int s = 0; s < 256; s++)
        begin
            m_valid[s] = 4'b0000;
            m_dirty[s] = 4'b0000;
            for (int w = 0; w < 4; w++)
            begin
                m_tag[s][w] = '0;
                m_age[s][w] = 2'(w); // way w at age w
            end
        end
    endfunction

    // bit 2 flags a hit, low bits give the way
    function automatic logic [2:0] model_lookup(l2_pkg::tag_t t, l2_pkg::index_t i);
        for (int w = 0; w < 4; w++)
            if (m_valid[i][w] && m_tag[i][w] == t)
                return {1'b1, 2'(w)};
        return 3'b000;
    endfunction

    function automatic logic [1:0] model_victim(l2_pkg::index_t i);
        for (int w = 0; w < 4; w++)
            if (!m_valid[i][w])
                return 2'(w);
        for (int w = 0; w < 4; w++)
            if (m_age[i][w] == 2'd3)
                return 2'(w);
        return 2'd0;
    endfunction

    function automatic void model_touch(l2_pkg::index_t i, logic [1:0] tw);
        logic [1:0] old;
        old = m_age[i][tw];
        for (int w = 0; w < 4; w++)
            if (m_age[i][w] < old)
                m_age[i][w] = m_age[i][w] + 2'd1;
        m_age[i][tw] = 2'd0;
    endfunction

    task automatic respond_mem(input int latency);
        repeat (latency) @(negedge clk);
        mem_ready = 1'b1;
        @(negedge clk);
        mem_ready = 1'b0;
    endtask

    // one L1 request, memory answered inline, response checked against the model
    task automatic run_access(input logic wr, input l2_pkg::tag_t t, input l2_pkg::index_t i,
                              input string name);
        logic [2:0]   look;
        logic         exp_wb;
        l2_pkg::tag_t exp_wb_tag;
        logic [1:0]   exp_way;
        look       = model_lookup(t, i);
        exp_wb     = 1'b0;
        exp_wb_tag = '0;
        exp_way    = look[1:0];
        if (!look[2])
        begin
            exp_way    = model_victim(i);
            exp_wb     = m_valid[i][exp_way] && m_dirty[i][exp_way];
            exp_wb_tag = m_tag[i][exp_way];
            m_tag[i][exp_way]   = t;
            m_valid[i][exp_way] = 1'b1;
            m_dirty[i][exp_way] = 1'b0;
        end
        model_touch(i, exp_way); // recheck after refill hits the new line
        if (wr)
            m_dirty[i][exp_way] = 1'b1;
        saw_wb     = 1'b0;
        saw_rd     = 1'b0;
        saw_refill = 1'b0;
        saw_upd    = 1'b0;
        wb_first   = 1'b0;
        timed_out  = 1'b1;
        cycles     = 0;
        @(negedge clk);
        read_req  = !wr;
        write_req = wr;
        req_tag   = t;
        req_index = i;
        while (cycles < TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
            if (mem_write)
            begin
                saw_wb   = 1'b1;
                wb_first = !saw_rd;
                wb_tag   = mem_tag;
                respond_mem(3);
            end
            else if (mem_read)
            begin
                saw_rd   = 1'b1;
                rd_tag   = mem_tag;
                rd_index = mem_index;
                respond_mem(5);
                saw_refill = refill; // pulse follows the mem_ready edge
                fill_way   = way;
            end
            if (ready)
            begin
                saw_upd   = update;
                end_way   = way;
                timed_out = 1'b0;
                break;
            end
        end
        read_req  = 1'b0;
        write_req = 1'b0;
        if (timed_out)
        begin
            $display("%s: ready never came within %0d cycles", name, TIMEOUT);
            errors++;
        end
        else
        begin
            if (look[2] && (saw_rd || saw_wb))
                report_mismatch($sformatf("%s: memory strobe on a hit", name));
            if (look[2] && cycles != 2)
                report_mismatch($sformatf("%s: ready after %0d cycles, not 2", name, cycles));
            if (!look[2] && (!saw_rd || rd_tag != t || rd_index != i))
                report_mismatch($sformatf("%s: mem_read tag %h index %h", name, rd_tag, rd_index));
            if (!look[2] && (!saw_refill || fill_way != exp_way))
                report_mismatch($sformatf("%s: refill way %0d, expected %0d", name,
                                          fill_way, exp_way));
            if (saw_wb != exp_wb)
                report_mismatch($sformatf("%s: write-back %0b, expected %0b", name,
                                          saw_wb, exp_wb));
            if (exp_wb && (wb_tag != exp_wb_tag || !wb_first))
                report_mismatch($sformatf("%s: write-back tag %h, expected %h", name,
                                          wb_tag, exp_wb_tag));
            if (end_way != exp_way)
                report_mismatch($sformatf("%s: way %0d, expected %0d", name, end_way, exp_way));
            if (saw_upd != wr)
                report_mismatch($sformatf("%s: update %0b with ready", name, saw_upd));
        end
    endtask

    task automatic test_reset_fill();
        int e0;
        e0 = errors;
        if (ready || refill || update || mem_read || mem_write || way != 2'd0)
            report_mismatch("outputs not at rest after reset");
        run_access(1'b0, tag_a, 8'h10, "fresh read");
        finish_test("reset_and_fill", e0);
    endtask

    task automatic test_repeat_hit();
        int e0;
        e0 = errors;
        run_access(1'b0, tag_a, 8'h10, "repeat read");
        finish_test("repeat_hit", e0);
    endtask

    task automatic test_write_back();
        int e0;
        e0 = errors;
        run_access(1'b1, tag_a, 8'h10, "write hit");
        for (int n = 1; n < 4; n++)
            run_access(1'b0, tag_a + l2_pkg::tag_t'(n), 8'h10, "fill set");
        run_access(1'b0, tag_a + 18'd4, 8'h10, "evict dirty");
        if (!saw_wb)
        begin
            $display("write_back: the dirty victim was never written to memory");
            errors++;
        end
        finish_test("write_back", e0);
    endtask

    task automatic test_replacement();
        int e0;
        e0 = errors;
        for (int n = 0; n < 4; n++)
            run_access(1'b0, tag_b + l2_pkg::tag_t'(n), 8'h55, "fill set");
        run_access(1'b0, tag_b + 18'd2, 8'h55, "touch");
        run_access(1'b0, tag_b, 8'h55, "touch");
        run_access(1'b0, tag_b + 18'd3, 8'h55, "touch");
        run_access(1'b0, tag_b + 18'd4, 8'h55, "fifth tag");
        finish_test("replacement", e0);
    endtask

    task automatic test_flush();
        int e0;
        e0 = errors;
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        for (int s = 0; s < 256; s++)
            m_valid[s] = 4'b0000; // ages and stale dirty bits stay
        run_access(1'b0, tag_b + 18'd2, 8'h55, "read after flush");
        finish_test("flush", e0);
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (nrst !== 1'b1 && n < 20)
        begin
            @(negedge clk);
            n++;
        end
        if (nrst !== 1'b1)
        begin
            $display("reset was never released");
            errors++;
        end
    endtask

    initial
    begin
        read_req  = 1'b0;
        write_req = 1'b0;
        flush     = 1'b0;
        mem_ready = 1'b0;
        req_tag   = '0;
        req_index = '0;
        errors    = 0;
        tests     = 0;
        failed    = 0;
        void'($urandom(32'h81f3b9b4));
        tag_a     = l2_pkg::tag_t'($urandom);
        tag_b     = l2_pkg::tag_t'($urandom);
        model_reset();
        wait_reset_release();
        test_reset_fill();
        test_repeat_hit();
        test_write_back();
        test_replacement();
        test_flush();
        $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic nrst
);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    // reset low for the first two rising edges
    initial
    begin
        nrst = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;
    end

endmodule

`default_nettype wire

// ==== src/l2_cache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_cache_ctrl (
    input  logic            clk,
    input  logic            nrst,
    input  logic            read_req,
    input  logic            write_req,
    input  logic            flush,
    input  l2_pkg::tag_t    req_tag,
    input  l2_pkg::index_t  req_index,
    input  logic            mem_ready,
    output logic            ready,
    output logic            refill,
    output logic            update,
    output logic            mem_read,
    output logic            mem_write,
    output l2_pkg::index_t  mem_index,
    output l2_pkg::tag_t    mem_tag,
    output l2_pkg::way_t    way
);

    l2_pkg::tag_t         lat_tag;
    l2_pkg::index_t       lat_index;
    logic                 lat_write;
    l2_pkg::ctrl_state_t  state;
    logic                 accept;
    logic                 do_hit;
    logic                 do_fill;
    logic                 do_wb_done;
    logic                 hit;
    logic                 victim_dirty;
    l2_pkg::way_t         hit_way;
    l2_pkg::way_t         victim_way;
    l2_pkg::tag_t         victim_tag;
    l2_pkg::set_ages_t    set_ages;

    l2_req_latch req_latch_inst (
        .clk, .nrst, .accept, .req_tag, .req_index, .write_req,
        .lat_tag, .lat_index, .lat_write
    );

    l2_ctrl_fsm ctrl_fsm_inst (
        .clk, .nrst, .read_req, .write_req, .flush, .mem_ready, .hit, .victim_dirty,
        .state, .accept, .do_hit, .do_fill, .do_wb_done
    );

    l2_tag_store tag_store_inst (
        .clk, .nrst, .flush, .lat_tag, .lat_index, .lat_write,
        .do_hit, .do_fill, .do_wb_done, .set_ages,
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag
    );

    // ages move only on a hit, refills are touched by the recheck
    l2_lru lru_inst (
        .clk, .nrst, .lat_index, .touch(do_hit), .touch_way(hit_way), .set_ages
    );

    l2_mem_port mem_port_inst (
        .clk, .nrst, .state, .do_hit, .do_fill, .lat_write, .lat_tag, .lat_index,
        .victim_tag, .hit_way, .victim_way,
        .ready, .refill, .update, .mem_read, .mem_write, .mem_index, .mem_tag, .way
    );

endmodule

`default_nettype wire

// ==== src/l2_consts.svh ====
`ifndef L2_CONSTS_SVH
`define L2_CONSTS_SVH

// cache geometry
`define L2_SETS     256
`define L2_WAYS     4
`define L2_TAG_W    18
`define L2_INDEX_W  8
`define L2_WAY_W    2

// lru age per way, 0 is most recent
`define L2_AGE_W    2

`endif

// ==== src/l2_ctrl_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_ctrl_fsm (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 read_req,
    input  logic                 write_req,
    input  logic                 flush,
    input  logic                 mem_ready,
    input  logic                 hit,
    input  logic                 victim_dirty,
    output l2_pkg::ctrl_state_t  state,
    output logic                 accept,
    output logic                 do_hit,
    output logic                 do_fill,
    output logic                 do_wb_done
);

    l2_pkg::ctrl_state_t next_state;

    // a flush cycle never starts a lookup
    assign accept     = (state == l2_pkg::s_idle) && (read_req || write_req) && !flush;
    assign do_hit     = (state == l2_pkg::s_compare) && hit;
    assign do_fill    = (state == l2_pkg::s_allocate) && mem_ready;
    assign do_wb_done = (state == l2_pkg::s_write_back) && mem_ready;

    always_comb
    begin
        next_state = state;
        case (state)
            l2_pkg::s_idle:
                if (accept)
                    next_state = l2_pkg::s_compare;
            l2_pkg::s_compare:
                if (hit)
                    next_state = l2_pkg::s_idle;
                else if (victim_dirty)
                    next_state = l2_pkg::s_write_back;
                else
                    next_state = l2_pkg::s_allocate;
            l2_pkg::s_write_back:
                if (mem_ready)
                    next_state = l2_pkg::s_allocate;
            l2_pkg::s_allocate:
                if (mem_ready)
                    next_state = l2_pkg::s_compare; // recheck, hits on the new line
            default:
                next_state = l2_pkg::s_idle;
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            state <= l2_pkg::s_idle;
        else
            state <= next_state;
    end

    // valid bits in the tag store may only be wiped between requests
    a_flush_idle: assert property (@(posedge clk) disable iff (!nrst)
        flush |-> (state == l2_pkg::s_idle) && !read_req && !write_req);

endmodule

`default_nettype wire

// ==== src/l2_lru.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l2_consts.svh"

module l2_lru (
    input  logic               clk,
    input  logic               nrst,
    input  l2_pkg::index_t     lat_index,
    input  logic               touch,
    input  l2_pkg::way_t       touch_way,
    output l2_pkg::set_ages_t  set_ages
);

    l2_pkg::set_ages_t  ages [`L2_SETS];
    l2_pkg::set_ages_t  next_ages;
    l2_pkg::age_t       old_age;

    function automatic logic is_perm(l2_pkg::set_ages_t a);
        logic [`L2_WAYS-1:0] seen;
        seen = '0;
        for (int w = 0; w < `L2_WAYS; w++)
            seen[a[w]] = 1'b1;
        return &seen;
    endfunction

    assign set_ages = ages[lat_index];
    assign old_age  = set_ages[touch_way];

    // touched way to 0, younger ones age by one
    always_comb
    begin
        for (int w = 0; w < `L2_WAYS; w++)
        begin
            if (l2_pkg::way_t'(w) == touch_way)
                next_ages[w] = '0;
            else if (set_ages[w] < old_age)
                next_ages[w] = set_ages[w] + 1'b1;
            else
                next_ages[w] = set_ages[w];
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int s = 0; s < `L2_SETS; s++)
                for (int w = 0; w < `L2_WAYS; w++)
                    ages[s][w] <= l2_pkg::age_t'(w); // way w starts at age w
        end
        else if (touch)
            ages[lat_index] <= next_ages;
    end

    // lat_index holds through the cycle after a hit
    a_ages_perm: assert property (@(posedge clk) disable iff (!nrst)
        touch |=> is_perm(set_ages));

endmodule

`default_nettype wire

// ==== src/l2_mem_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_mem_port (
    input  logic                 clk,
    input  logic                 nrst,
    input  l2_pkg::ctrl_state_t  state,
    input  logic                 do_hit,
    input  logic                 do_fill,
    input  logic                 lat_write,
    input  l2_pkg::tag_t         lat_tag,
    input  l2_pkg::index_t       lat_index,
    input  l2_pkg::tag_t         victim_tag,
    input  l2_pkg::way_t         hit_way,
    input  l2_pkg::way_t         victim_way,
    output logic                 ready,
    output logic                 refill,
    output logic                 update,
    output logic                 mem_read,
    output logic                 mem_write,
    output l2_pkg::index_t       mem_index,
    output l2_pkg::tag_t         mem_tag,
    output l2_pkg::way_t         way
);

    assign mem_read  = (state == l2_pkg::s_allocate);
    assign mem_write = (state == l2_pkg::s_write_back);
    assign mem_index = lat_index;
    assign mem_tag   = mem_write ? victim_tag : lat_tag; // old line out, new line in

    // pulses to L1 and the data array one cycle after the event
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            ready  <= 1'b0;
            refill <= 1'b0;
            update <= 1'b0;
            way    <= '0;
        end
        else
        begin
            ready  <= do_hit;
            refill <= do_fill;
            update <= do_hit && lat_write;
            if (do_hit)
                way <= hit_way;
            else if (do_fill)
                way <= victim_way;
        end
    end

    // address held steady while memory is strobed
    a_mem_addr_stable: assert property (@(posedge clk) disable iff (!nrst)
        (mem_read && $past(mem_read)) || (mem_write && $past(mem_write))
            |-> $stable(mem_tag) && $stable(mem_index));

endmodule

`default_nettype wire

// ==== src/l2_pkg.sv ====
`default_nettype none

package l2_pkg;

`include "l2_consts.svh"

    typedef logic [`L2_TAG_W-1:0]   tag_t;
    typedef logic [`L2_INDEX_W-1:0] index_t;
    typedef logic [`L2_WAY_W-1:0]   way_t;
    typedef logic [`L2_AGE_W-1:0]   age_t;

    typedef age_t [`L2_WAYS-1:0] set_ages_t; // field w is way w

    typedef enum logic [1:0] {
        s_idle       = 2'b00,
        s_compare    = 2'b01,
        s_write_back = 2'b10,
        s_allocate   = 2'b11
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== src/l2_req_latch.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_req_latch (
    input  logic            clk,
    input  logic            nrst,
    input  logic            accept,
    input  l2_pkg::tag_t    req_tag,
    input  l2_pkg::index_t  req_index,
    input  logic            write_req,
    output l2_pkg::tag_t    lat_tag,
    output l2_pkg::index_t  lat_index,
    output logic            lat_write
);

    // address of the request in flight
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            lat_tag   <= req_tag;
            lat_index <= req_index;
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            lat_write <= 1'b0;
        else if (accept)
            lat_write <= write_req; // read when low
    end

endmodule

`default_nettype wire

// ==== src/l2_tag_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l2_consts.svh"

module l2_tag_store (
    input  logic               clk,
    input  logic               nrst,
    input  logic               flush,
    input  l2_pkg::tag_t       lat_tag,
    input  l2_pkg::index_t     lat_index,
    input  logic               lat_write,
    input  logic               do_hit,
    input  logic               do_fill,
    input  logic               do_wb_done,
    input  l2_pkg::set_ages_t  set_ages,
    output logic               hit,
    output l2_pkg::way_t       hit_way,
    output l2_pkg::way_t       victim_way,
    output logic               victim_dirty,
    output l2_pkg::tag_t       victim_tag
);

    l2_pkg::tag_t             tags  [`L2_SETS][`L2_WAYS];
    logic [`L2_WAYS-1:0]      valid [`L2_SETS];
    logic [`L2_WAYS-1:0]      dirty [`L2_SETS];
    logic [`L2_WAYS-1:0]      match;

    // way compare for the latched set
    always_comb
    begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `L2_WAYS; w++)
        begin
            match[w] = valid[lat_index][w] && (tags[lat_index][w] == lat_tag);
            if (match[w])
            begin
                hit     = 1'b1;
                hit_way = l2_pkg::way_t'(w);
            end
        end
    end

    // first free way, else the oldest one
    always_comb
    begin
        logic found;
        found      = 1'b0;
        victim_way = '0;
        for (int w = 0; w < `L2_WAYS; w++)
        begin
            if (!found && !valid[lat_index][w])
            begin
                victim_way = l2_pkg::way_t'(w);
                found      = 1'b1;
            end
        end
        if (!found)
        begin
            for (int w = 0; w < `L2_WAYS; w++)
                if (set_ages[w] == '1)
                    victim_way = l2_pkg::way_t'(w);
        end
    end

    // stale dirty bits survive a flush
    assign victim_dirty = valid[lat_index][victim_way] && dirty[lat_index][victim_way];
    assign victim_tag   = tags[lat_index][victim_way];

    always_ff @(posedge clk)
    begin
        if (do_fill)
            tags[lat_index][victim_way] <= lat_tag;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int s = 0; s < `L2_SETS; s++)
            begin
                valid[s] <= '0;
                dirty[s] <= '0;
            end
        end
        else if (flush)
        begin
            for (int s = 0; s < `L2_SETS; s++)
                valid[s] <= '0;
        end
        else if (do_fill)
        begin
            valid[lat_index][victim_way] <= 1'b1;
            dirty[lat_index][victim_way] <= 1'b0; // fresh from memory
        end
        else if (do_hit && lat_write)
            dirty[lat_index][hit_way] <= 1'b1;
        else if (do_wb_done)
            dirty[lat_index][victim_way] <= 1'b0;
    end

    a_single_match: assert property (@(posedge clk) disable iff (!nrst) $onehot0(match));

endmodule

`default_nettype wire
